// File: verilog.f
quant_cfg_pkg.sv
quant_data_pkg.sv
quant_if.sv
quant_cfg_regs.sv
quant_bias_add.sv
quant_shift_relu.sv
quant_clamp.sv
quant_top.sv
tb_clk_gen.sv
quant_checker.sv
quant_tb.sv

// File: Bender.yml
package:
  name: quant

sources:
  - files:
      - quant_cfg_pkg.sv
      - quant_data_pkg.sv
      - quant_if.sv
      - quant_cfg_regs.sv
      - quant_bias_add.sv
      - quant_shift_relu.sv
      - quant_clamp.sv
      - quant_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - quant_checker.sv
      - quant_tb.sv

// File: quant_tb.sv
`timescale 1ns/1ps
`default_nettype none

module quant_tb;

  localparam int lane_num = 4;
  localparam int lanes = 2 * lane_num;
  localparam int aw = quant_data_pkg::acc_width;
  localparam int qw = quant_data_pkg::q_width;
  // about 200 cycles of tests, limit at ten times that
  localparam int test_cycles = 200;
  localparam int cycle_limit = 10 * test_cycles;

  logic clk;
  logic rst_n;
  logic cyc;
  logic stb;
  logic we;
  logic [quant_cfg_pkg::wb_aw-1:0] adr;
  logic [quant_cfg_pkg::wb_dw-1:0] dat_w;
  logic [quant_cfg_pkg::wb_sel_w-1:0] sel;
  logic [quant_cfg_pkg::wb_dw-1:0] dat_r;
  logic ack;
  logic in_valid;
  logic [lanes-1:0][aw-1:0] acc_vector;
  logic [lanes*qw-1:0] quant_vector;
  logic out_valid;

  logic [7:0] cur_scale_lo;
  logic [7:0] cur_scale_hi;
  logic [7:0] cur_bias_lo;
  logic [7:0] cur_bias_hi;
  logic cur_no_relu;
  logic [lanes*qw-1:0] exp_q[$];
  int n_sent;
  int cycles;

  tb_clk_gen #(.period(4.0), .reset_cycles(8)) i_clk_gen (.clk(clk), .rst_n(rst_n));

  quant_top #(.lane_num(lane_num)) i_quant_top (
    .clk(clk), .rst_n(rst_n),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack),
    .in_valid(in_valid), .acc_vector(acc_vector),
    .quant_vector(quant_vector), .out_valid(out_valid)
  );

  bind quant_top quant_checker i_checker (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .ack(ack),
    .in_valid(in_valid), .out_valid(out_valid)
  );

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // bias, shift, then saturate to one byte
  function automatic logic [7:0] model_byte(input logic signed [23:0] acc,
                                            input logic signed [7:0] bias,
                                            input logic [7:0] scale, input logic no_relu);
    longint v;
    longint r;
    v = longint'(acc) + longint'(bias);
    if (!no_relu) begin
      r = (v < 0 || scale >= 32) ? 0 : (v >> scale);
      if (r > 255) r = 255;
    end else begin
      if (scale >= 32) r = (v < 0) ? -1 : 0;
      else r = v >>> scale;
      if (r < -128) r = -128;
      else if (r > 127) r = 127;
    end
    return r[7:0];
  endfunction

  task automatic wb_cycle(input logic wr, input logic [3:0] a, input logic [31:0] d,
                          input logic [3:0] s, output logic [31:0] rd);
    cyc = 1'b1;
    stb = 1'b1;
    we = wr;
    adr = a;
    dat_w = d;
    sel = s;
    @(negedge clk);
    while (!ack) @(negedge clk);
    rd = dat_r;
    // hold the strobe through the ack edge
    @(negedge clk);
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic set_cfg(input logic [7:0] s_lo, input logic [7:0] s_hi,
                         input logic [7:0] b_lo, input logic [7:0] b_hi, input logic nr);
    logic [31:0] rd;
    wb_cycle(1'b1, quant_cfg_pkg::reg_scale, {16'h0, s_hi, s_lo}, 4'b0011, rd);
    wb_cycle(1'b1, quant_cfg_pkg::reg_bias, {16'h0, b_hi, b_lo}, 4'b0011, rd);
    wb_cycle(1'b1, quant_cfg_pkg::reg_ctrl, {31'h0, nr}, 4'b0001, rd);
    cur_scale_lo = s_lo;
    cur_scale_hi = s_hi;
    cur_bias_lo = b_lo;
    cur_bias_hi = b_hi;
    cur_no_relu = nr;
  endtask

  // one vector for one cycle, expected bytes queued for the monitor
  task automatic send_vector(input logic [lanes-1:0][aw-1:0] acc);
    logic [lanes*qw-1:0] e;
    for (int i = 0; i < lanes; i++) begin
      e[i*qw +: qw] = (i < lane_num) ?
          model_byte(acc[i], cur_bias_lo, cur_scale_lo, cur_no_relu) :
          model_byte(acc[i], cur_bias_hi, cur_scale_hi, cur_no_relu);
    end
    exp_q.push_back(e);
    n_sent++;
    in_valid = 1'b1;
    acc_vector = acc;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid went high with no vector outstanding");
        $display("tests failed");
        $fatal(1);
      end else begin
        for (int i = 0; i < lanes; i++) begin
          compare_value($sformatf("quant_vector[%0d]", i), quant_vector[i*qw +: qw],
                        exp_q[0][i*qw +: qw]);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (i_quant_top.i_checker.n_fail != 0) begin
      $display("an assertion in the bound checker failed");
      $display("tests failed");
      $fatal(1);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("tests failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic test_registers();
    logic [31:0] rd;
    wb_cycle(1'b1, quant_cfg_pkg::reg_scale, 32'h1234_5678, 4'b0001, rd);
    wb_cycle(1'b1, quant_cfg_pkg::reg_scale, 32'h0000_ab00, 4'b0010, rd);
    wb_cycle(1'b0, quant_cfg_pkg::reg_scale, 32'h0, 4'b1111, rd);
    compare_value("dat_r scale", rd, 32'h0000_ab78);
    wb_cycle(1'b1, quant_cfg_pkg::reg_bias, 32'hdead_c3f0, 4'b1111, rd);
    wb_cycle(1'b0, quant_cfg_pkg::reg_bias, 32'h0, 4'b1111, rd);
    compare_value("dat_r bias", rd, 32'h0000_c3f0);
    wb_cycle(1'b1, quant_cfg_pkg::reg_ctrl, 32'h1, 4'b0001, rd);
    // no byte enabled, ctrl keeps its value
    wb_cycle(1'b1, quant_cfg_pkg::reg_ctrl, 32'h0, 4'b0000, rd);
    wb_cycle(1'b0, quant_cfg_pkg::reg_ctrl, 32'h0, 4'b1111, rd);
    compare_value("dat_r ctrl", rd, 32'h1);
    wb_cycle(1'b1, quant_cfg_pkg::reg_count, 32'h0000_1234, 4'b1111, rd);
    wb_cycle(1'b0, quant_cfg_pkg::reg_count, 32'h0, 4'b1111, rd);
    compare_value("dat_r count", rd, 32'h0);
  endtask

  task automatic test_relu();
    // negative, in range and saturating lanes in both groups
    set_cfg(8'd2, 8'd5, 8'd3, -8'sd4, 1'b0);
    send_vector({24'd8195, 24'd100000, 24'd4000, -24'sd1,
                 24'd1021, 24'd5000, 24'd400, -24'sd100});
  endtask

  task automatic test_signed();
    // hi group shifts by 40, leaving only the sign
    set_cfg(8'd3, 8'd40, -8'sd7, 8'd5, 1'b1);
    send_vector({-24'sd8388608, 24'd8388607, -24'sd100, -24'sd3,
                 24'd100, 24'd2000, -24'sd5000, -24'sd900});
  endtask

  task automatic test_streaming();
    logic [lanes-1:0][aw-1:0] acc;
    logic [7:0] new_lo;
    logic [7:0] new_hi;
    set_cfg(8'($urandom_range(4, 14)), 8'($urandom_range(4, 14)),
            8'($urandom()), 8'($urandom()), 1'($urandom()));
    new_lo = 8'($urandom_range(0, 40));
    new_hi = 8'($urandom_range(0, 40));
    for (int n = 0; n < 20; n++) begin
      for (int i = 0; i < lanes; i++) acc[i] = aw'($urandom());
      // scale write issued alongside vector 10, seen from vector 11 on
      if (n == 10) begin
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = quant_cfg_pkg::reg_scale;
        dat_w = {16'h0, new_hi, new_lo};
        sel = 4'b0011;
      end
      send_vector(acc);
      if (n == 10) begin
        compare_value("ack", ack, 32'h1);
        cur_scale_lo = new_lo;
        cur_scale_hi = new_hi;
      end
      if (n == 11) begin
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
      end
    end
  endtask

  task automatic test_count();
    logic [31:0] rd;
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    wb_cycle(1'b0, quant_cfg_pkg::reg_count, 32'h0, 4'b1111, rd);
    compare_value("dat_r count", rd, n_sent);
  endtask

  initial begin
    void'($urandom(32'hdf6c_0871));
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    sel = '0;
    in_valid = 1'b0;
    acc_vector = '0;
    n_sent = 0;
    cycles = 0;
    @(posedge rst_n);
    test_registers();
    test_relu();
    test_signed();
    test_streaming();
    test_count();
    if (i_quant_top.i_checker.n_fail == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("bound checker reported %0d assertion failures",
               i_quant_top.i_checker.n_fail);
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: quant_checker.sv
`timescale 1ns/1ps
`default_nettype none

module quant_checker (
  input logic clk,
  input logic rst_n,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic in_valid,
  input logic out_valid
);

  // failed assertions so far
  int n_fail = 0;

  // fixed three stage latency
  assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 3))
    else begin
      n_fail++;
      $error("out_valid does not follow in_valid by three cycles");
    end

  assert property (@(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb))
    else begin
      n_fail++;
      $error("ack high without an active cyc and stb");
    end

  // single cycle ack under a held strobe
  assert property (@(posedge clk) disable iff (!rst_n) (ack && stb) |=> !ack)
    else begin
      n_fail++;
      $error("ack held for two cycles while stb stayed high");
    end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real period = 4.0,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

  // release on a falling edge, like all other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: quant_top.sv
`timescale 1ns/1ps
`default_nettype none

module quant_top #(
  parameter int lane_num = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // wishbone slave
  input  logic                               cyc,
  input  logic                               stb,
  input  logic                               we,
  input  logic [quant_cfg_pkg::wb_aw-1:0]    adr,
  input  logic [quant_cfg_pkg::wb_dw-1:0]    dat_w,
  input  logic [quant_cfg_pkg::wb_sel_w-1:0] sel,
  output logic [quant_cfg_pkg::wb_dw-1:0]    dat_r,
  output logic                               ack,
  // accumulator vector in, quantized bytes out
  input  logic                               in_valid,
  input  logic [2*lane_num*quant_data_pkg::acc_width-1:0] acc_vector,
  output logic [2*lane_num*quant_data_pkg::q_width-1:0]   quant_vector,
  output logic                               out_valid
);

  quant_cfg_if cfg ();
  quant_biased_if #(.lane_num(lane_num)) biased ();
  quant_scaled_if #(.lane_num(lane_num)) scaled ();

  quant_cfg_regs i_regs (
    .clk(clk), .rst_n(rst_n),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack),
    .out_valid(out_valid),
    .cfg(cfg.regs)
  );

  //////////////////////////////////////////////////
  // three stage datapath
  //////////////////////////////////////////////////
  quant_bias_add #(.lane_num(lane_num)) i_bias_add (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .acc_vector(acc_vector),
    .cfg(cfg.dp), .bo(biased.src)
  );

  quant_shift_relu #(.lane_num(lane_num)) i_shift_relu (
    .clk(clk), .rst_n(rst_n),
    .bi(biased.dst), .so(scaled.src)
  );

  quant_clamp #(.lane_num(lane_num)) i_clamp (
    .clk(clk), .rst_n(rst_n),
    .si(scaled.dst),
    .quant_vector(quant_vector), .out_valid(out_valid)
  );

endmodule

`default_nettype wire

// File: quant_clamp.sv
`timescale 1ns/1ps
`default_nettype none

module quant_clamp #(
  parameter int lane_num = 4
) (
  input  logic clk,
  input  logic rst_n,
  quant_scaled_if.dst si,
  output logic [2*lane_num*quant_data_pkg::q_width-1:0] quant_vector,
  output logic out_valid
);

  localparam int qw = quant_data_pkg::q_width;
  localparam int lw = quant_data_pkg::lane_width;

  logic [2*lane_num*qw-1:0] q_next;

  for (genvar i = 0; i < 2*lane_num; i++) begin : g_lane
    logic signed [lw-1:0] shift_s;
    quant_data_pkg::q_byte_t q;

    assign shift_s = si.shift_lanes[i];

    always_comb begin
      q = '0;
      if (!si.no_relu) begin
        // relu form is never negative, only the top needs a limit
        if (si.relu_lanes[i] > quant_data_pkg::q_u_max) q.u8 = 8'hff;
        else q.u8 = si.relu_lanes[i][qw-1:0];
      end else begin
        if (shift_s < quant_data_pkg::q_s_min) q.s8 = 8'sh80;
        else if (shift_s > quant_data_pkg::q_s_max) q.s8 = 8'sh7f;
        else q.s8 = shift_s[qw-1:0];
      end
    end

    assign q_next[i*qw +: qw] = q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= si.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (si.valid) quant_vector <= q_next;
  end

endmodule

`default_nettype wire

// File: quant_shift_relu.sv
`timescale 1ns/1ps
`default_nettype none

module quant_shift_relu #(
  parameter int lane_num = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  quant_biased_if.dst  bi,
  quant_scaled_if.src  so
);

  localparam int lw = quant_data_pkg::lane_width;

  logic [2*lane_num-1:0][lw-1:0] relu_next;
  logic [2*lane_num-1:0][lw-1:0] shift_next;

  //////////////////////////////////////////////////
  // per-lane shift, scale picked by channel group
  //////////////////////////////////////////////////
  for (genvar i = 0; i < 2*lane_num; i++) begin : g_lane
    logic signed [lw-1:0] lane_s;
    logic [quant_data_pkg::bias_width-1:0] scale;

    assign lane_s = bi.lanes[i];
    assign scale = (i < lane_num) ? bi.scale_lo : bi.scale_hi;

    // negative lanes drop to zero in relu form
    assign relu_next[i] = lane_s[lw-1] ? '0 : (lane_s >> scale);
    // sign fill, so scale >= 32 leaves 0 or -1
    assign shift_next[i] = lane_s >>> scale;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      so.valid <= 1'b0;
    end else begin
      so.valid <= bi.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (bi.valid) begin
      so.relu_lanes <= relu_next;
      so.shift_lanes <= shift_next;
      so.no_relu <= bi.no_relu;
    end
  end

endmodule

`default_nettype wire

// File: quant_bias_add.sv
`timescale 1ns/1ps
`default_nettype none

module quant_bias_add #(
  parameter int lane_num = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic [2*lane_num*quant_data_pkg::acc_width-1:0] acc_vector,
  quant_cfg_if.dp      cfg,
  quant_biased_if.src  bo
);

  localparam int aw = quant_data_pkg::acc_width;

  logic [2*lane_num-1:0][quant_data_pkg::lane_width-1:0] sum;

  // lanes below lane_num take bias_lo
  for (genvar i = 0; i < 2*lane_num; i++) begin : g_lane
    logic signed [aw-1:0] acc_s;
    logic signed [quant_data_pkg::bias_width-1:0] bias_s;
    logic signed [quant_data_pkg::lane_width-1:0] sum_s;

    assign acc_s = acc_vector[i*aw +: aw];
    assign bias_s = (i < lane_num) ? cfg.bias_lo : cfg.bias_hi;
    // both operands signed, so both extend to 32 bits
    assign sum_s = acc_s + bias_s;
    assign sum[i] = sum_s;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bo.valid <= 1'b0;
    end else begin
      bo.valid <= in_valid;
    end
  end

  // config sampled with the vector it applies to
  always_ff @(posedge clk) begin
    if (in_valid) begin
      bo.lanes <= sum;
      bo.scale_lo <= cfg.scale_lo;
      bo.scale_hi <= cfg.scale_hi;
      bo.no_relu <= cfg.no_relu;
    end
  end

endmodule

`default_nettype wire

// File: quant_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module quant_cfg_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            cyc,
  input  logic                            stb,
  input  logic                            we,
  input  logic [quant_cfg_pkg::wb_aw-1:0] adr,
  input  logic [quant_cfg_pkg::wb_dw-1:0] dat_w,
  input  logic [quant_cfg_pkg::wb_sel_w-1:0] sel,
  output logic [quant_cfg_pkg::wb_dw-1:0] dat_r,
  output logic                            ack,
  input  logic                            out_valid,
  quant_cfg_if.regs                       cfg
);

  logic req;
  logic [15:0] scale_q;
  logic [15:0] bias_q;
  logic no_relu_q;
  logic [quant_cfg_pkg::count_width-1:0] count_q;
  logic [quant_cfg_pkg::wb_dw-1:0] rd_data;

  // one request per ack, a held strobe is answered every other cycle
  assign req = cyc & stb & ~ack;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  //////////////////////////////////////////////////
  // byte-masked writes
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scale_q <= quant_cfg_pkg::scale_default;
      bias_q <= quant_cfg_pkg::bias_default;
      no_relu_q <= quant_cfg_pkg::no_relu_default;
    end else if (req && we) begin
      for (int b = 0; b < quant_cfg_pkg::field_bytes; b++) begin
        if (sel[b] && adr == quant_cfg_pkg::reg_scale) scale_q[b*8 +: 8] <= dat_w[b*8 +: 8];
        if (sel[b] && adr == quant_cfg_pkg::reg_bias) bias_q[b*8 +: 8] <= dat_w[b*8 +: 8];
      end
      if (sel[0] && adr == quant_cfg_pkg::reg_ctrl) no_relu_q <= dat_w[0];
    end
  end

  // wraps at 16 bits, not writable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (out_valid) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    rd_data = '0;
    case (adr)
      quant_cfg_pkg::reg_scale: rd_data[15:0] = scale_q;
      quant_cfg_pkg::reg_bias:  rd_data[15:0] = bias_q;
      quant_cfg_pkg::reg_ctrl:  rd_data[0] = no_relu_q;
      quant_cfg_pkg::reg_count: rd_data[quant_cfg_pkg::count_width-1:0] = count_q;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) dat_r <= rd_data;
  end

  assign cfg.scale_lo = scale_q[7:0];
  assign cfg.scale_hi = scale_q[15:8];
  assign cfg.bias_lo = bias_q[7:0];
  assign cfg.bias_hi = bias_q[15:8];
  assign cfg.no_relu = no_relu_q;

endmodule

`default_nettype wire

// File: quant_if.sv
`timescale 1ns/1ps
`default_nettype none

// per-layer configuration from the register block
interface quant_cfg_if;
  logic [quant_data_pkg::bias_width-1:0] scale_lo;
  logic [quant_data_pkg::bias_width-1:0] scale_hi;
  logic signed [quant_data_pkg::bias_width-1:0] bias_lo;
  logic signed [quant_data_pkg::bias_width-1:0] bias_hi;
  logic no_relu;

  modport regs (output scale_lo, scale_hi, bias_lo, bias_hi, no_relu);
  modport dp (input scale_lo, scale_hi, bias_lo, bias_hi, no_relu);
endinterface

// biased lanes plus the config that rides with them
interface quant_biased_if #(
  parameter int lane_num = 4
);
  logic valid;
  logic [2*lane_num-1:0][quant_data_pkg::lane_width-1:0] lanes;
  logic [quant_data_pkg::bias_width-1:0] scale_lo;
  logic [quant_data_pkg::bias_width-1:0] scale_hi;
  logic no_relu;

  modport src (output valid, lanes, scale_lo, scale_hi, no_relu);
  modport dst (input valid, lanes, scale_lo, scale_hi, no_relu);
endinterface

// both shifted forms of every lane
interface quant_scaled_if #(
  parameter int lane_num = 4
);
  logic valid;
  logic [2*lane_num-1:0][quant_data_pkg::lane_width-1:0] relu_lanes;
  logic [2*lane_num-1:0][quant_data_pkg::lane_width-1:0] shift_lanes;
  logic no_relu;

  modport src (output valid, relu_lanes, shift_lanes, no_relu);
  modport dst (input valid, relu_lanes, shift_lanes, no_relu);
endinterface

`default_nettype wire

// File: quant_data_pkg.sv
`default_nettype none

package quant_data_pkg;

  // lane widths through the pipeline
  localparam int acc_width = 24;
  localparam int bias_width = 8;
  localparam int lane_width = acc_width + bias_width;
  localparam int q_width = 8;

  // saturation limits of the output byte
  localparam int q_u_max = 255;
  localparam int q_s_max = 127;
  localparam int q_s_min = -128;

  // one output byte, uint8 in relu mode and int8 otherwise
  typedef union packed {
    logic [q_width-1:0] u8;
    logic signed [q_width-1:0] s8;
  } q_byte_t;

endpackage

`default_nettype wire

// File: quant_cfg_pkg.sv
`default_nettype none

package quant_cfg_pkg;

  // wishbone bus widths
  localparam int wb_aw = 4;
  localparam int wb_dw = 32;
  localparam int wb_sel_w = wb_dw / 8;

  // register map, byte addresses
  localparam logic [wb_aw-1:0] reg_scale = 4'h0;
  localparam logic [wb_aw-1:0] reg_bias = 4'h4;
  localparam logic [wb_aw-1:0] reg_ctrl = 4'h8;
  localparam logic [wb_aw-1:0] reg_count = 4'hc;

  // output vector counter
  localparam int count_width = 16;

  // scale and bias hold two byte fields, hi group in the upper byte
  localparam int field_bytes = 2;

  // reset values of the configuration registers
  localparam logic [15:0] scale_default = 16'h0000;
  localparam logic [15:0] bias_default = 16'h0000;
  localparam logic no_relu_default = 1'b0;

endpackage

`default_nettype wire
